/* src/cam_capture_pkg.sv */
// Sizes are shrunk for simulation, and INTERLEAVED_FRAMES has to divide LINES_PER_FRAME evenly
package cam_capture_pkg;

    // ********************
    // Input conditioning
    // ********************

    // Flip-flop stages ahead of the three-deep vote buffer
    localparam int SYNC_STAGES = 4;
    // System clocks from the filtered pixel clock fall to the sample strobe, never below 1
    localparam int PIX_SAMPLE_DELAY = 2;
    localparam int PIXEL_WIDTH = 12;
    // Only the upper bits of each pixel are stored
    localparam int BYTE_WIDTH = 8;

    // ********************
    // Frame geometry
    // ********************

    localparam int PIXELS_PER_LINE = 8;
    localparam int LINES_PER_FRAME = 16;
    localparam int COUNT_WIDTH = 12;

    // Lines are taken in Bayer pairs, so the average stride equals the frame count
    localparam int INTERLEAVED_FRAMES = 2;
    localparam int INTERLEAVE_JUMP = 2 * INTERLEAVED_FRAMES - 1;
    localparam int LINES_PER_INTERLEAVED = LINES_PER_FRAME / INTERLEAVED_FRAMES;

    // ********************
    // Boot timing
    // ********************

    localparam int BOOT_CYCLES = 64;
    localparam int WAKE_CYCLES = 64;
    // Wide enough for either boot or wake interval
    localparam int STATE_TIMER_WIDTH = $clog2(BOOT_CYCLES + WAKE_CYCLES);

    // Camera pins as one word, so every bit sees the same delay
    typedef struct packed {
        logic                   pixclk;
        logic                   fv;
        logic                   lv;
        logic [PIXEL_WIDTH-1:0] data;
    } cam_bus_t;

    // Filtered levels, the sample strobe and the byte to store
    typedef struct packed {
        logic                  fv;
        logic                  lv;
        logic                  blank;
        logic                  out_of_frame;
        logic                  sample;
        logic [BYTE_WIDTH-1:0] pixel_byte;
    } cond_bus_t;

    // Position of the sensor within the current frame
    typedef struct packed {
        logic                   line_active;
        logic [COUNT_WIDTH-1:0] line_in_frame;
        logic [COUNT_WIDTH-1:0] prev_line;
        logic                   line_done;
    } line_pos_t;

endpackage

/* src/input_conditioner.sv */
// Needs at least four system clocks per pixel clock phase so the three-deep vote settles in time
`timescale 1ns/1ps

module input_conditioner (
    input  logic                       clk,
    input  logic                       arst_n,
    input  cam_capture_pkg::cam_bus_t  cam,
    output cam_capture_pkg::cond_bus_t cond
);
    import cam_capture_pkg::*;

    // Pin word through the synchronizer chain
    cam_bus_t sync_q [SYNC_STAGES];
    // Three consecutive samples for the vote
    cam_bus_t vote_q [3];
    cam_bus_t vote;
    cam_bus_t vote_prev;
    cam_bus_t fell;
    logic     blank;
    logic [PIX_SAMPLE_DELAY-1:0] strobe_pipe;

    // ********************
    // Synchronizer chain
    // ********************

    // The whole bus shifts together, so data and pixel clock keep one fixed latency
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '0;
            end
            for (int i = 0; i < 3; i++) begin
                vote_q[i] <= '0;
            end
            vote_prev <= '0;
        end else begin
            sync_q[0] <= cam;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            vote_q[0] <= sync_q[SYNC_STAGES-1];
            vote_q[1] <= vote_q[0];
            vote_q[2] <= vote_q[1];
            // One word of history for the edge detectors
            vote_prev <= vote;
        end
    end

    // ********************
    // Vote and edges
    // ********************

    // Bitwise two-of-three majority drops any blip shorter than two clocks
    assign vote = (vote_q[2] & vote_q[1]) | (vote_q[2] & vote_q[0]) | (vote_q[1] & vote_q[0]);
    // Falling edges of every filtered bit, one clock wide
    assign fell = vote_prev & ~vote;

    // Data is held for several clocks after the pixel clock falls, so sample a little later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            strobe_pipe <= '0;
        end else begin
            strobe_pipe[0] <= fell.pixclk;
            for (int i = 1; i < PIX_SAMPLE_DELAY; i++) begin
                strobe_pipe[i] <= strobe_pipe[i-1];
            end
        end
    end

    // Blanking means all data bits read zero
    assign blank = (vote.data == '0);

    assign cond.fv = vote.fv;
    assign cond.lv = vote.lv;
    assign cond.blank = blank;
    // Frame gap only when every input agrees
    assign cond.out_of_frame = !vote.fv && !vote.lv && blank;
    assign cond.sample = strobe_pipe[PIX_SAMPLE_DELAY-1];
    assign cond.pixel_byte = vote.data[PIXEL_WIDTH-1 -: BYTE_WIDTH];

endmodule

/* src/line_tracker.sv */
// Expects zero data during every blanking interval, since line ends and frame gaps are found that way
`timescale 1ns/1ps

module line_tracker (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       tracking,
    input  cam_capture_pkg::cond_bus_t cond,
    output cam_capture_pkg::line_pos_t pos
);
    import cam_capture_pkg::*;

    logic                   line_active;
    logic                   wait_line_end;
    logic [COUNT_WIDTH-1:0] pixel_count;
    logic [COUNT_WIDTH-1:0] line_in_frame;
    logic [COUNT_WIDTH-1:0] prev_line;
    logic                   can_advance;
    logic                   line_done;

    // ********************
    // Line state
    // ********************

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_active   <= 1'b0;
            wait_line_end <= 1'b0;
            pixel_count   <= '0;
        end else if (!tracking) begin
            // Camera is not trusted yet, so hold everything clear
            line_active   <= 1'b0;
            wait_line_end <= 1'b0;
            pixel_count   <= '0;
        end else if (line_active) begin
            // A line closes only after a full line of pixels
            // Greater-or-equal lets an upset count still close the line
            if (pixel_count >= COUNT_WIDTH'(PIXELS_PER_LINE)) begin
                line_active   <= 1'b0;
                pixel_count   <= '0;
                // LV is probably still high here, so block re-entry into the same line
                wait_line_end <= 1'b1;
            end else if (cond.sample) begin
                pixel_count <= pixel_count + 1'b1;
            end
        end else begin
            if (!cond.lv && cond.blank) begin
                wait_line_end <= 1'b0;
            end
            if (cond.lv && !wait_line_end) begin
                line_active <= 1'b1;
            end
        end
    end

    // ********************
    // Line counter
    // ********************

    // The line number advances in the blanking after each line, never during one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_in_frame <= '0;
            prev_line     <= '0;
            can_advance   <= 1'b0;
            line_done     <= 1'b0;
        end else if (!tracking) begin
            line_in_frame <= '0;
            prev_line     <= '0;
            can_advance   <= 1'b0;
            line_done     <= 1'b0;
        end else begin
            line_done <= 1'b0;
            // Arm the advance once a line has really been entered
            if (line_active) begin
                can_advance <= 1'b1;
            end
            if (!line_active && !cond.lv && cond.blank && can_advance) begin
                can_advance   <= 1'b0;
                prev_line     <= line_in_frame;
                line_in_frame <= line_in_frame + 1'b1;
                line_done     <= 1'b1;
            end
            // Frame gap wins over the advance, and prev_line still gets the last line
            if (cond.out_of_frame && !line_active) begin
                prev_line     <= line_in_frame;
                line_in_frame <= '0;
            end
        end
    end

    assign pos.line_active   = line_active;
    assign pos.line_in_frame = line_in_frame;
    assign pos.prev_line     = prev_line;
    assign pos.line_done     = line_done;

endmodule

/* src/interleave_selector.sv */
// Relies on INTERLEAVED_FRAMES dividing LINES_PER_FRAME, or the last pairs of lines get split
`timescale 1ns/1ps

module interleave_selector (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       streaming,
    input  cam_capture_pkg::cond_bus_t cond,
    input  cam_capture_pkg::line_pos_t pos,
    output logic                       keep_pixel,
    output logic                       all_done
);
    import cam_capture_pkg::*;

    // Three copies of the target line, so one upset cannot stall the capture
    logic [COUNT_WIDTH-1:0] target_q [3];
    logic [COUNT_WIDTH-1:0] target;
    logic [COUNT_WIDTH-1:0] next_target;
    logic [COUNT_WIDTH-1:0] restart_target;
    logic [COUNT_WIDTH-1:0] line_in_ilv;
    logic [COUNT_WIDTH-1:0] frame_idx;
    logic                   target_hit;

    // ********************
    // Target line
    // ********************

    assign target = (target_q[2] & target_q[1]) | (target_q[2] & target_q[0])
                  | (target_q[1] & target_q[0]);

    // Read two lines, then skip ahead, which keeps each Bayer pair whole
    always_comb begin
        if (!target[0]) begin
            next_target = target + 1'b1;
        end else if (target < COUNT_WIDTH'(LINES_PER_FRAME - INTERLEAVE_JUMP)) begin
            next_target = target + COUNT_WIDTH'(INTERLEAVE_JUMP);
        end else begin
            // Past the frame end, fall back to a line that earlier frames dropped
            next_target = target + COUNT_WIDTH'(INTERLEAVE_JUMP - INTERLEAVED_FRAMES + 1);
        end
    end

    // Each interleaved frame begins two lines further down than the one before
    assign restart_target = frame_idx + frame_idx + COUNT_WIDTH'(2);

    // The line that just finished was one of ours
    assign target_hit = pos.line_done && (pos.prev_line == target);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 3; i++) begin
                target_q[i] <= '0;
            end
            line_in_ilv <= '0;
            frame_idx   <= '0;
            all_done    <= 1'b0;
        end else if (!streaming) begin
            // Start every image from line 0 of interleaved frame 0
            for (int i = 0; i < 3; i++) begin
                target_q[i] <= '0;
            end
            line_in_ilv <= '0;
            frame_idx   <= '0;
            all_done    <= 1'b0;
        end else if (target_hit) begin
            if (line_in_ilv >= COUNT_WIDTH'(LINES_PER_INTERLEAVED - 1)) begin
                line_in_ilv <= '0;
                if (frame_idx >= COUNT_WIDTH'(INTERLEAVED_FRAMES - 1)) begin
                    all_done <= 1'b1;
                end else begin
                    frame_idx <= frame_idx + 1'b1;
                    for (int i = 0; i < 3; i++) begin
                        target_q[i] <= restart_target;
                    end
                end
            end else begin
                line_in_ilv <= line_in_ilv + 1'b1;
                for (int i = 0; i < 3; i++) begin
                    target_q[i] <= next_target;
                end
            end
        end else if (cond.out_of_frame && (target >= COUNT_WIDTH'(LINES_PER_FRAME))) begin
            // Target can never match again, so close the image early in the frame gap
            all_done <= 1'b1;
        end
    end

    // Write enable for the whole selected line while streaming
    assign keep_pixel = pos.line_active && (pos.line_in_frame == target) && streaming;

endmodule

/* src/capture_fsm.sv */
// Warm-up and start of capture wait on real frame gaps, so their latency follows the sensor
`timescale 1ns/1ps

module capture_fsm (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       request_image,
    input  logic                       all_done,
    input  cam_capture_pkg::cond_bus_t cond,
    output logic                       camera_reset_n,
    output logic                       tracking,
    output logic                       streaming
);
    import cam_capture_pkg::*;

    typedef enum logic [2:0] {
        ST_BOOT,
        ST_WAKE,
        ST_WAIT_FRAME_START,
        ST_WAIT_FRAME_END,
        ST_IDLE,
        ST_ARMED,
        ST_STREAMING
    } state_t;

    state_t                       state;
    state_t                       state_next;
    logic [STATE_TIMER_WIDTH-1:0] state_timer;

    // ********************
    // Next state
    // ********************

    always_comb begin
        state_next = state;
        case (state)
            ST_BOOT: begin
                if (state_timer == STATE_TIMER_WIDTH'(BOOT_CYCLES - 1)) begin
                    state_next = ST_WAKE;
                end
            end
            ST_WAKE: begin
                if (state_timer == STATE_TIMER_WIDTH'(WAKE_CYCLES - 1)) begin
                    state_next = ST_WAIT_FRAME_START;
                end
            end
            // Let one whole frame go by so tracking starts in a frame gap
            ST_WAIT_FRAME_START: begin
                if (cond.fv) begin
                    state_next = ST_WAIT_FRAME_END;
                end
            end
            ST_WAIT_FRAME_END: begin
                if (cond.out_of_frame) begin
                    state_next = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (request_image) begin
                    state_next = ST_ARMED;
                end
            end
            // Never start in the middle of a frame
            ST_ARMED: begin
                if (cond.out_of_frame) begin
                    state_next = ST_STREAMING;
                end
            end
            ST_STREAMING: begin
                if (all_done) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_BOOT;
        endcase
    end

    // Timer restarts on every state change and only runs while it is needed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= ST_BOOT;
            state_timer <= '0;
        end else begin
            state <= state_next;
            if (state_next != state) begin
                state_timer <= '0;
            end else if (state == ST_BOOT || state == ST_WAKE) begin
                state_timer <= state_timer + 1'b1;
            end
        end
    end

    // Camera stays in reset only during boot
    assign camera_reset_n = (state != ST_BOOT);
    assign tracking = (state == ST_IDLE) || (state == ST_ARMED) || (state == ST_STREAMING);
    assign streaming = (state == ST_STREAMING);

endmodule

/* src/camera_capture_top.sv */
// No back-pressure exists, so a full FIFO downstream silently loses bytes
`timescale 1ns/1ps

module camera_capture_top (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic                                   pixel_clock,
    input  logic                                   fv,
    input  logic                                   lv,
    input  logic [cam_capture_pkg::PIXEL_WIDTH-1:0] pixel_in,
    input  logic                                   request_image,
    output logic                                   camera_reset_n,
    output logic [cam_capture_pkg::BYTE_WIDTH-1:0]  data_for_fifo,
    output logic                                   sample_pixel_pulse,
    output logic                                   keep_pixel,
    output logic                                   capturing
);
    import cam_capture_pkg::*;

    cam_bus_t  cam;
    cond_bus_t cond;
    line_pos_t pos;
    logic      tracking;
    logic      streaming;
    logic      all_done;

    // Camera pins travel as one word from here on
    assign cam = '{pixclk: pixel_clock, fv: fv, lv: lv, data: pixel_in};

    input_conditioner u_input_conditioner (
        .clk    (clk),
        .arst_n (arst_n),
        .cam    (cam),
        .cond   (cond)
    );

    line_tracker u_line_tracker (
        .clk      (clk),
        .arst_n   (arst_n),
        .tracking (tracking),
        .cond     (cond),
        .pos      (pos)
    );

    interleave_selector u_interleave_selector (
        .clk        (clk),
        .arst_n     (arst_n),
        .streaming  (streaming),
        .cond       (cond),
        .pos        (pos),
        .keep_pixel (keep_pixel),
        .all_done   (all_done)
    );

    capture_fsm u_capture_fsm (
        .clk            (clk),
        .arst_n         (arst_n),
        .request_image  (request_image),
        .all_done       (all_done),
        .cond           (cond),
        .camera_reset_n (camera_reset_n),
        .tracking       (tracking),
        .streaming      (streaming)
    );

    // A byte is written when the strobe and keep_pixel are high together
    assign data_for_fifo = cond.pixel_byte;
    assign sample_pixel_pulse = cond.sample;
    assign capturing = streaming;

endmodule

/* tests/camera_capture_assertions.sv */
// Sees only the top-level pins, so internal counters and the interleave state go unchecked
`timescale 1ns/1ps

module camera_capture_assertions (
    input logic clk,
    input logic arst_n,
    input logic camera_reset_n,
    input logic sample_pixel_pulse,
    input logic keep_pixel,
    input logic capturing
);
    // Number of assertion failures, read by the testbench at the end
    int unsigned failures = 0;

    // FIFO write enable only while an image is being captured
    // Capture starts in a frame gap, so no line can be kept on the first capturing clock
    keep_needs_capture: assert property (@(posedge clk) disable iff (!arst_n)
        keep_pixel |-> capturing && $past(capturing))
        else begin
            $error("keep_pixel is high outside a capture that began on an earlier clock");
            failures++;
        end

    // The sample strobe is a single-clock pulse
    strobe_one_clock: assert property (@(posedge clk) disable iff (!arst_n)
        sample_pixel_pulse |=> !sample_pixel_pulse)
        else begin
            $error("sample_pixel_pulse stayed high for more than one clock");
            failures++;
        end

    // Camera must stay in reset while the system is in reset
    camera_held_in_reset: assert property (@(posedge clk) !arst_n |-> !camera_reset_n)
        else begin
            $error("camera_reset_n is high during system reset");
            failures++;
        end

endmodule

bind camera_capture_top camera_capture_assertions u_assertions (
    .clk                (clk),
    .arst_n             (arst_n),
    .camera_reset_n     (camera_reset_n),
    .sample_pixel_pulse (sample_pixel_pulse),
    .keep_pixel         (keep_pixel),
    .capturing          (capturing)
);

/* tests/tb_camera_capture.sv */
// Camera model runs 8 system clocks per pixel, and its glitches are single-clock blips the filter hides
`timescale 1ns/1ps

module tb_camera_capture;
    import cam_capture_pkg::*;

    // ********************
    // Camera geometry
    // ********************

    // Each line is followed by 4 blank pixel periods and each frame by 8
    localparam int LINE_PERIODS  = PIXELS_PER_LINE + 4;
    localparam int FRAME_ACTIVE  = LINES_PER_FRAME * LINE_PERIODS;
    localparam int FRAME_PERIODS = FRAME_ACTIVE + 8;
    localparam int FRAME_CLOCKS  = FRAME_PERIODS * 8;
    // Pixel store wraps after this many sensor frames
    localparam int STORED_FRAMES = 16;
    localparam int IMAGE_BYTES   = INTERLEAVED_FRAMES * LINES_PER_INTERLEAVED * PIXELS_PER_LINE;
    localparam int NUM_TESTS     = 3;

    typedef struct {
        string name;
        int    req_offset;
        bit    glitch;
    } test_entry_t;

    logic                   clk;
    logic                   arst_n;
    logic                   pixel_clock;
    logic                   fv;
    logic                   lv;
    logic [PIXEL_WIDTH-1:0] pixel_in;
    logic                   request_image;
    logic                   camera_reset_n;
    logic [BYTE_WIDTH-1:0]  data_for_fifo;
    logic                   sample_pixel_pulse;
    logic                   keep_pixel;
    logic                   capturing;

    test_entry_t            tests [NUM_TESTS];
    logic [PIXEL_WIDTH-1:0] pix_mem [STORED_FRAMES][LINES_PER_FRAME][PIXELS_PER_LINE];
    logic [BYTE_WIDTH-1:0]  captured_q [$];
    int                     clk_in_period;
    int                     period;
    int                     frame_count;
    int                     stray_writes;
    bit                     glitch_en;
    bit                     test_active;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    camera_capture_top dut (
        .clk                (clk),
        .arst_n             (arst_n),
        .pixel_clock        (pixel_clock),
        .fv                 (fv),
        .lv                 (lv),
        .pixel_in           (pixel_in),
        .request_image      (request_image),
        .camera_reset_n     (camera_reset_n),
        .data_for_fifo      (data_for_fifo),
        .sample_pixel_pulse (sample_pixel_pulse),
        .keep_pixel         (keep_pixel),
        .capturing          (capturing)
    );

    // ********************
    // Pixel store
    // ********************

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Nonzero pixels only, so a zero word always means blanking
    task automatic fill_pixels();
        logic [31:0] state;
        state = 32'hfd40;
        for (int f = 0; f < STORED_FRAMES; f++) begin
            for (int l = 0; l < LINES_PER_FRAME; l++) begin
                for (int p = 0; p < PIXELS_PER_LINE; p++) begin
                    state = lcg_next(state);
                    pix_mem[f][l][p] = (state[27:16] == '0) ? 12'h001 : state[27:16];
                end
            end
        end
    endtask

    // Image frame k holds the Bayer pairs starting at line 2k, every 2N lines
    function automatic int expected_line(input int ilv_frame, input int slot);
        return 2 * ilv_frame + 2 * INTERLEAVED_FRAMES * (slot / 2) + (slot % 2);
    endfunction

    task automatic abort_run(input string reason);
        $display("Timeout while %s", reason);
        $display("Simulation failed");
        $finish;
    endtask

    // ********************
    // Camera model
    // ********************

    // Data and LV change at the pixel clock rise and hold for the whole pixel period
    always @(posedge clk) begin : camera_model
        int                     pix_idx;
        logic                   line_on;
        logic [PIXEL_WIDTH-1:0] value;
        pix_idx = period % LINE_PERIODS;
        line_on = (period < FRAME_ACTIVE) && (pix_idx < PIXELS_PER_LINE);
        value = '0;
        if (line_on) begin
            value = pix_mem[frame_count % STORED_FRAMES][period / LINE_PERIODS][pix_idx];
        end
        if (camera_reset_n !== 1'b1) begin
            clk_in_period <= 0;
            period        <= 0;
            frame_count   <= 0;
            pixel_clock   <= 1'b0;
            fv            <= 1'b0;
            lv            <= 1'b0;
            pixel_in      <= '0;
        end else begin
            pixel_clock <= (clk_in_period < 4);
            fv          <= (period < FRAME_ACTIVE);
            // Blips sit at least two clocks away from any real edge
            lv       <= line_on ^ (glitch_en && clk_in_period == 2 && period % 3 == 1);
            pixel_in <= value ^ ((glitch_en && clk_in_period == 5) ? 12'h5a5 : 12'h000);
            if (clk_in_period == 7) begin
                clk_in_period <= 0;
                if (period == FRAME_PERIODS - 1) begin
                    period      <= 0;
                    frame_count <= frame_count + 1;
                end else begin
                    period <= period + 1;
                end
            end else begin
                clk_in_period <= clk_in_period + 1;
            end
        end
    end

    // FIFO side of the DUT, sampled away from the driving edge
    always @(negedge clk) begin
        if (sample_pixel_pulse === 1'b1 && keep_pixel === 1'b1) begin
            if (test_active) begin
                captured_q.push_back(data_for_fifo);
            end else begin
                stray_writes++;
            end
        end
    end

    // ********************
    // Test sequence
    // ********************

    initial begin : main_sequence
        int                     waited;
        int                     req_frame;
        int                     errors_in_test;
        int                     tests_failed;
        int                     check_failures;
        int                     ilv_frame;
        int                     slot;
        logic [PIXEL_WIDTH-1:0] pixel;
        logic [BYTE_WIDTH-1:0]  expected;
        arst_n         <= 1'b0;
        pixel_clock    <= 1'b0;
        fv             <= 1'b0;
        lv             <= 1'b0;
        pixel_in       <= '0;
        request_image  <= 1'b0;
        tests_failed   = 0;
        check_failures = 0;
        tests[0] = '{name: "mid_frame_request", req_offset: 50, glitch: 1'b0};
        tests[1] = '{name: "gap_request", req_offset: FRAME_ACTIVE + 4, glitch: 1'b0};
        tests[2] = '{name: "glitched_bus", req_offset: 100, glitch: 1'b1};
        fill_pixels();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;

        for (int t = 0; t < NUM_TESTS; t++) begin
            errors_in_test = 0;
            glitch_en <= tests[t].glitch;
            // Warm-up is over once the camera has finished its first frame
            waited = 0;
            while (!(camera_reset_n === 1'b1 && capturing === 1'b0 && frame_count >= 1)) begin
                @(posedge clk);
                waited++;
                if (waited > 3 * FRAME_CLOCKS) begin
                    abort_run("waiting for the DUT to go idle");
                end
            end
            if (t == 0 && stray_writes != 0) begin
                $display("Bytes were written before the first request (%0d)", stray_writes);
                check_failures++;
            end
            waited = 0;
            while (!(period == tests[t].req_offset && clk_in_period == 0)) begin
                @(posedge clk);
                waited++;
                if (waited > 2 * FRAME_CLOCKS) begin
                    abort_run("waiting for the request point in the frame");
                end
            end
            // The image is the first sensor frame that starts after the request
            req_frame = frame_count;
            captured_q.delete();
            test_active   <= 1'b1;
            request_image <= 1'b1;
            @(posedge clk);
            request_image <= 1'b0;
            waited = 0;
            while (capturing !== 1'b1) begin
                @(posedge clk);
                waited++;
                if (waited > 2 * FRAME_CLOCKS) begin
                    abort_run("waiting for capturing to rise");
                end
            end
            waited = 0;
            while (capturing !== 1'b0) begin
                @(posedge clk);
                waited++;
                if (waited > 3 * FRAME_CLOCKS) begin
                    abort_run("waiting for capturing to fall");
                end
            end
            test_active <= 1'b0;

            if (captured_q.size() != IMAGE_BYTES) begin
                $display("ERROR %s byte count expected %0d actual %0d",
                         tests[t].name, IMAGE_BYTES, captured_q.size());
                errors_in_test++;
            end
            for (int i = 0; i < captured_q.size() && i < IMAGE_BYTES; i++) begin
                ilv_frame = i / (LINES_PER_INTERLEAVED * PIXELS_PER_LINE);
                slot = (i / PIXELS_PER_LINE) % LINES_PER_INTERLEAVED;
                pixel = pix_mem[(req_frame + 1 + ilv_frame) % STORED_FRAMES]
                               [expected_line(ilv_frame, slot)][i % PIXELS_PER_LINE];
                expected = pixel[PIXEL_WIDTH-1 -: BYTE_WIDTH];
                if (captured_q[i] !== expected) begin
                    $display("ERROR %s byte %0d expected %02h actual %02h",
                             tests[t].name, i, expected, captured_q[i]);
                    errors_in_test++;
                end
            end
            if (errors_in_test != 0) begin
                tests_failed++;
            end
            $display("%s: %0d bytes, %0d mismatches, %s", tests[t].name, captured_q.size(),
                     errors_in_test, (errors_in_test == 0) ? "passed" : "failed");
        end

        // Writes after a capture has ended land in the stray counter too
        if (stray_writes != 0) begin
            $display("Bytes were written outside a capture (%0d)", stray_writes);
            check_failures++;
        end
        if (dut.u_assertions.failures != 0) begin
            $display("Bound assertions failed %0d times", dut.u_assertions.failures);
            check_failures++;
        end
        $display("Tests run %0d, passed %0d, failed %0d, other check failures %0d",
                 NUM_TESTS, NUM_TESTS - tests_failed, tests_failed, check_failures);
        if (tests_failed == 0 && check_failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/cam_capture_pkg.sv
src/input_conditioner.sv
src/line_tracker.sv
src/interleave_selector.sv
src/capture_fsm.sv
src/camera_capture_top.sv
tests/camera_capture_assertions.sv
tests/tb_camera_capture.sv
